// File: hw/wb_pkg.sv
//----------------------------
// Writeback-commit shared definitions
// Register file sizing and arbiter state type
//----------------------------

package wb_pkg;

  //----------------------------
  // Register file geometry
  //----------------------------

  // Width of an architectural register address
  localparam int REG_ADDR_BITS = 5;

  // Architectural register count, r0 hardwired to zero
  localparam int NUM_REGS = 32;

  //----------------------------
  // Arbiter state
  //----------------------------

  // Idle: no result accepted on the last edge
  // Granted: a result was accepted and the pointer already moved
  typedef enum logic {
    ARB_IDLE    = 1'b0,
    ARB_GRANTED = 1'b1
  } arb_state_e;

endpackage

// File: hw/wb_arbiter.sv
//----------------------------
// Writeback round-robin arbiter
// Picks one valid execute pipe per cycle and
// returns ready to the winner only
//----------------------------

`timescale 1ns/1ps

module wb_arbiter #(
  parameter int num_pipes = 2,
  parameter int data_bits = 32
) (
  input  logic                                            clk,
  input  logic                                            reset,
  input  logic [num_pipes-1:0]                            x_val,
  input  logic [num_pipes-1:0][wb_pkg::REG_ADDR_BITS-1:0] x_waddr,
  input  logic [num_pipes-1:0][data_bits-1:0]             x_wdata,
  input  logic [num_pipes-1:0]                            x_wen,
  output logic [num_pipes-1:0]                            x_rdy,
  output logic                                            fire,
  output logic [wb_pkg::REG_ADDR_BITS-1:0]                sel_waddr,
  output logic [data_bits-1:0]                            sel_wdata,
  output logic                                            sel_wen
);

  // Pointer needs at least one bit even with a single pipe
  localparam int ptr_bits = (num_pipes > 1) ? $clog2(num_pipes) : 1;

  // Pipe with highest priority this cycle
  logic [ptr_bits-1:0] ptr;
  logic [ptr_bits-1:0] ptr_next;

  // Winner index and whether any pipe is valid
  logic [ptr_bits-1:0] win;
  logic                found;

  wb_pkg::arb_state_e  state;

  //----------------------------
  // Winner search
  //----------------------------

  // Walk from the farthest offset down to the pointer
  // so the pipe closest to the pointer wins last
  always_comb begin
    int idx;
    win   = '0;
    found = 1'b0;
    for (int i = num_pipes - 1; i >= 0; i--) begin
      idx = int'(ptr) + i;
      // Wrap without a modulo, idx stays below 2*num_pipes
      if (idx >= num_pipes) begin
        idx = idx - num_pipes;
      end
      if (x_val[idx]) begin
        win   = ptr_bits'(idx);
        found = 1'b1;
      end
    end
  end

  // One-hot ready, only for the winning valid pipe
  always_comb begin
    x_rdy = '0;
    if (found) begin
      x_rdy[win] = 1'b1;
    end
  end

  // Ready always lands on a valid pipe, so any winner transfers
  assign fire = found;

  // Winner fields toward commit unit and register file
  assign sel_waddr = x_waddr[win];
  assign sel_wdata = x_wdata[win];
  assign sel_wen   = x_wen[win];

  //----------------------------
  // Pointer and state update
  //----------------------------

  // Next priority goes to the pipe after the winner
  assign ptr_next = (win == ptr_bits'(num_pipes - 1)) ? '0 : win + 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr   <= '0;
      state <= wb_pkg::ARB_IDLE;
    end else begin
      if (fire) begin
        ptr <= ptr_next;
      end
      state <= fire ? wb_pkg::ARB_GRANTED : wb_pkg::ARB_IDLE;
    end
  end

endmodule

// File: hw/wb_commit.sv
//----------------------------
// Writeback commit unit
// Numbers each accepted result and pulses a
// one-cycle completion notification
//----------------------------

`timescale 1ns/1ps

module wb_commit #(
  parameter int data_bits    = 32,
  parameter int seq_num_bits = 8
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             fire,
  input  logic [wb_pkg::REG_ADDR_BITS-1:0] sel_waddr,
  input  logic [data_bits-1:0]             sel_wdata,
  input  logic                             sel_wen,
  output logic                             rf_wen,
  output logic                             complete_val,
  output logic [seq_num_bits-1:0]          complete_seq_num,
  output logic [wb_pkg::REG_ADDR_BITS-1:0] complete_waddr,
  output logic [data_bits-1:0]             complete_wdata,
  output logic                             complete_wen
);

  // Next sequence number to hand out
  logic [seq_num_bits-1:0] seq_cnt;

  //----------------------------
  // Register file write
  //----------------------------

  // Same edge as the transfer
  // r0 and wen-low results never reach the file
  assign rf_wen = fire && sel_wen && (sel_waddr != '0);

  //----------------------------
  // Sequence counter
  //----------------------------

  // Wraps modulo 2^seq_num_bits on its own
  always_ff @(posedge clk) begin
    if (reset) begin
      seq_cnt <= '0;
    end else if (fire) begin
      seq_cnt <= seq_cnt + 1'b1;
    end
  end

  //----------------------------
  // Completion notification
  //----------------------------

  // Strobe is high for exactly the cycle after each fire
  always_ff @(posedge clk) begin
    if (reset) begin
      complete_val <= 1'b0;
    end else begin
      complete_val <= fire;
    end
  end

  // Payload only loads on a transfer
  // Reports the wen as sent, r0 writes still complete
  always_ff @(posedge clk) begin
    if (fire) begin
      complete_seq_num <= seq_cnt;
      complete_waddr   <= sel_waddr;
      complete_wdata   <= sel_wdata;
      complete_wen     <= sel_wen;
    end
  end

endmodule

// File: hw/wb_regfile.sv
//----------------------------
// Architectural register file
// One write port, one combinational read port, r0 reads zero
//----------------------------

`timescale 1ns/1ps

module wb_regfile #(
  parameter int data_bits = 32
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             wen,
  input  logic [wb_pkg::REG_ADDR_BITS-1:0] waddr,
  input  logic [data_bits-1:0]             wdata,
  input  logic [wb_pkg::REG_ADDR_BITS-1:0] raddr,
  output logic [data_bits-1:0]             rdata
);

  // No storage behind r0
  logic [data_bits-1:0] regs [1:wb_pkg::NUM_REGS-1];

  //----------------------------
  // Write port
  //----------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      // Architectural state starts at zero
      for (int i = 1; i < wb_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  //----------------------------
  // Read port
  //----------------------------

  // New value visible the cycle after the write edge
  always_comb begin
    if (raddr == '0) begin
      rdata = '0;
    end else begin
      rdata = regs[raddr];
    end
  end

endmodule

// File: hw/wb_top.sv
//----------------------------
// Writeback-commit stage top level
// Arbiter, commit unit and register file
//----------------------------

`timescale 1ns/1ps

module wb_top #(
  parameter int num_pipes    = 2,
  parameter int data_bits    = 32,
  parameter int seq_num_bits = 8
) (
  input  logic                                            clk,
  input  logic                                            reset,

  // Execute pipe results, one slice per pipe
  input  logic [num_pipes-1:0]                            x_val,
  input  logic [num_pipes-1:0][wb_pkg::REG_ADDR_BITS-1:0] x_waddr,
  input  logic [num_pipes-1:0][data_bits-1:0]             x_wdata,
  input  logic [num_pipes-1:0]                            x_wen,
  output logic [num_pipes-1:0]                            x_rdy,

  // Completion strobe, no back-pressure
  output logic                                            complete_val,
  output logic [seq_num_bits-1:0]                         complete_seq_num,
  output logic [wb_pkg::REG_ADDR_BITS-1:0]                complete_waddr,
  output logic [data_bits-1:0]                            complete_wdata,
  output logic                                            complete_wen,

  // Debug read port
  input  logic [wb_pkg::REG_ADDR_BITS-1:0]                dbg_raddr,
  output logic [data_bits-1:0]                            dbg_rdata
);

  // Arbiter to commit unit and register file
  logic                             fire;
  logic [wb_pkg::REG_ADDR_BITS-1:0] sel_waddr;
  logic [data_bits-1:0]             sel_wdata;
  logic                             sel_wen;

  // Filtered write enable from commit unit
  logic                             rf_wen;

  //----------------------------
  // Pipe selection
  //----------------------------

  wb_arbiter #(
    .num_pipes (num_pipes),
    .data_bits (data_bits)
  ) u_arb (
    .clk       (clk),
    .reset     (reset),
    .x_val     (x_val),
    .x_waddr   (x_waddr),
    .x_wdata   (x_wdata),
    .x_wen     (x_wen),
    .x_rdy     (x_rdy),
    .fire      (fire),
    .sel_waddr (sel_waddr),
    .sel_wdata (sel_wdata),
    .sel_wen   (sel_wen)
  );

  //----------------------------
  // Commit and notification
  //----------------------------

  wb_commit #(
    .data_bits    (data_bits),
    .seq_num_bits (seq_num_bits)
  ) u_commit (
    .clk              (clk),
    .reset            (reset),
    .fire             (fire),
    .sel_waddr        (sel_waddr),
    .sel_wdata        (sel_wdata),
    .sel_wen          (sel_wen),
    .rf_wen           (rf_wen),
    .complete_val     (complete_val),
    .complete_seq_num (complete_seq_num),
    .complete_waddr   (complete_waddr),
    .complete_wdata   (complete_wdata),
    .complete_wen     (complete_wen)
  );

  // Written on the transfer edge, not on the notification
  wb_regfile #(
    .data_bits (data_bits)
  ) u_rf (
    .clk   (clk),
    .reset (reset),
    .wen   (rf_wen),
    .waddr (sel_waddr),
    .wdata (sel_wdata),
    .raddr (dbg_raddr),
    .rdata (dbg_rdata)
  );

endmodule

// File: dv/wb_checker.sv
//----------------------------
// Writeback-commit assertions
// Handshake and sequence-number properties
//----------------------------

`timescale 1ns/1ps

module wb_checker #(
  parameter int num_pipes    = 2,
  parameter int seq_num_bits = 8
) (
  input logic                    clk,
  input logic                    reset,
  input logic [num_pipes-1:0]    x_val,
  input logic [num_pipes-1:0]    x_rdy,
  input wb_pkg::arb_state_e      arb_state,
  input logic                    complete_val,
  input logic [seq_num_bits-1:0] complete_seq_num
);

  // Last reported sequence number
  logic [seq_num_bits-1:0] last_seq;
  logic                    have_prev;

  always_ff @(posedge clk) begin
    if (reset) begin
      have_prev <= 1'b0;
      last_seq  <= '0;
    end else if (complete_val) begin
      have_prev <= 1'b1;
      last_seq  <= complete_seq_num;
    end
  end

  //----------------------------
  // Properties
  //----------------------------

  // One grant per cycle at most
  rdy_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(x_rdy))
    else $error("more than one x_rdy high");

  // Grant only to a requesting pipe
  rdy_on_val: assert property (@(posedge clk) disable iff (reset) (x_rdy & ~x_val) == '0)
    else $error("x_rdy high on a pipe without x_val");

  // Strobe quiet while reset holds
  quiet_in_reset: assert property (@(posedge clk) reset && $past(reset) |-> !complete_val)
    else $error("complete_val high during reset");

  // Numbers step by one and wrap at the width
  seq_step: assert property (@(posedge clk) disable iff (reset)
      complete_val && have_prev |-> complete_seq_num == seq_num_bits'(last_seq + 1'b1))
    else $error("complete_seq_num did not step by one");

  // Granted exactly when a pipe handshake happened on the last edge
  state_tracks_grant: assert property (@(posedge clk) disable iff (reset)
      !$past(reset) |-> (arb_state == wb_pkg::ARB_GRANTED) == $past(|(x_val & x_rdy)))
    else $error("arbiter state does not match the last handshake");

endmodule

bind wb_top wb_checker #(
  .num_pipes    (num_pipes),
  .seq_num_bits (seq_num_bits)
) u_chk (
  .clk              (clk),
  .reset            (reset),
  .x_val            (x_val),
  .x_rdy            (x_rdy),
  .arb_state        (u_arb.state),
  .complete_val     (complete_val),
  .complete_seq_num (complete_seq_num)
);

// File: dv/wb_tb.sv
//----------------------------
// Writeback-commit testbench
// Golden-file stimulus, round-robin model,
// completion and register checks
//----------------------------

`timescale 1ns/1ps

module wb_tb;

  localparam int num_pipes    = 2;
  localparam int data_bits    = 32;
  localparam int seq_num_bits = 8;
  localparam int rec_words    = 8;
  localparam int max_recs     = 32;
  localparam int drain_limit  = 2000;

  logic                                            clk;
  logic                                            reset;
  logic [num_pipes-1:0]                            x_val;
  logic [num_pipes-1:0][wb_pkg::REG_ADDR_BITS-1:0] x_waddr;
  logic [num_pipes-1:0][data_bits-1:0]             x_wdata;
  logic [num_pipes-1:0]                            x_wen;
  logic [num_pipes-1:0]                            x_rdy;
  logic                                            complete_val;
  logic [seq_num_bits-1:0]                         complete_seq_num;
  logic [wb_pkg::REG_ADDR_BITS-1:0]                complete_waddr;
  logic [data_bits-1:0]                            complete_wdata;
  logic                                            complete_wen;
  logic [wb_pkg::REG_ADDR_BITS-1:0]                dbg_raddr;
  logic [data_bits-1:0]                            dbg_rdata;

  // Golden records of rec_words words each
  logic [31:0] golden [0:rec_words*max_recs-1];

  // Per-pipe pending results {wen, waddr, wdata}
  logic [37:0] pend [num_pipes][$];
  // Expected completions {seq, wen, waddr, wdata}
  logic [45:0] exp_q [$];
  logic [data_bits-1:0] shadow [0:wb_pkg::NUM_REGS-1];

  integer seed;
  int ptr_m;
  logic [seq_num_bits-1:0] seq_m;
  logic [wb_pkg::REG_ADDR_BITS-1:0] rd_ptr;
  int cmp_errors;
  int other_errors;

  always #2 clk = ~clk;

  wb_top #(
    .num_pipes    (num_pipes),
    .data_bits    (data_bits),
    .seq_num_bits (seq_num_bits)
  ) UUT (
    .clk              (clk),
    .reset            (reset),
    .x_val            (x_val),
    .x_waddr          (x_waddr),
    .x_wdata          (x_wdata),
    .x_wen            (x_wen),
    .x_rdy            (x_rdy),
    .complete_val     (complete_val),
    .complete_seq_num (complete_seq_num),
    .complete_waddr   (complete_waddr),
    .complete_wdata   (complete_wdata),
    .complete_wen     (complete_wen),
    .dbg_raddr        (dbg_raddr),
    .dbg_rdata        (dbg_rdata)
  );

  task automatic compare(input string name, input logic [63:0] act, input logic [63:0] exp);
    if (act !== exp) begin
      cmp_errors++;
      $display("error at %0t ns: %s got %0h expected %0h", $time, name, act, exp);
    end
  endtask

  function automatic int pending_total();
    int n;
    n = 0;
    for (int p = 0; p < num_pipes; p++) begin
      n += pend[p].size();
    end
    return n;
  endfunction

  //----------------------------
  // One clock of drive and check
  //----------------------------

  task automatic step_cycle();
    logic [num_pipes-1:0] exp_rdy;
    logic [45:0]          c;
    logic [37:0]          r;
    int                   win;
    int                   idx;
    @(posedge clk);
    // Head of each queue stays put until granted
    for (int p = 0; p < num_pipes; p++) begin
      if (pend[p].size() > 0) begin
        x_val[p]                             <= 1'b1;
        {x_wen[p], x_waddr[p], x_wdata[p]}   <= pend[p][0];
      end else begin
        x_val[p] <= 1'b0;
      end
    end
    // Read back the register of the result committing on this edge
    // Sweep all addresses when nothing commits
    if (exp_q.size() > 0) begin
      dbg_raddr <= exp_q[0][36:32];
    end else begin
      dbg_raddr <= rd_ptr;
      rd_ptr    <= rd_ptr + 1'b1;
    end
    @(negedge clk);
    // Notification for the previous edge's transfer
    if (exp_q.size() > 0) begin
      c = exp_q.pop_front();
      compare("complete_val", 64'(complete_val), 64'(1));
      compare("complete_seq_num", 64'(complete_seq_num), 64'(c[45:38]));
      compare("complete_wen", 64'(complete_wen), 64'(c[37]));
      compare("complete_waddr", 64'(complete_waddr), 64'(c[36:32]));
      compare("complete_wdata", 64'(complete_wdata), 64'(c[31:0]));
    end else begin
      compare("complete_val", 64'(complete_val), 64'(0));
    end
    compare("dbg_rdata", 64'(dbg_rdata), 64'(shadow[dbg_raddr]));
    // Round-robin model from the pipe after the last grant
    win = -1;
    for (int i = 0; i < num_pipes; i++) begin
      idx = (ptr_m + i) % num_pipes;
      if (win < 0 && x_val[idx]) begin
        win = idx;
      end
    end
    exp_rdy = '0;
    if (win >= 0) begin
      exp_rdy[win] = 1'b1;
    end
    compare("x_rdy", 64'(x_rdy), 64'(exp_rdy));
    if (win >= 0) begin
      r = pend[win].pop_front();
      exp_q.push_back({seq_m, r});
      seq_m = seq_m + 1'b1;
      if (r[37] && r[36:32] != '0) begin
        shadow[r[36:32]] = r[31:0];
      end
      ptr_m = (win + 1) % num_pipes;
    end
  endtask

  // Run until every pipe is empty and every completion is seen
  task automatic drain();
    int n;
    n = 0;
    while ((pending_total() > 0 || exp_q.size() > 0) && n < drain_limit) begin
      step_cycle();
      n++;
    end
    if (n >= drain_limit) begin
      other_errors++;
      $display("timeout: pipes did not drain within %0d cycles", drain_limit);
    end
  endtask

  // Random offers on random pipes to high registers only
  task automatic random_stretch(input int cycles);
    logic [4:0]  a;
    logic [31:0] d;
    logic        w;
    for (int c = 0; c < cycles; c++) begin
      for (int p = 0; p < num_pipes; p++) begin
        if (($random(seed) & 1) != 0 && pend[p].size() < 2) begin
          a = 5'(8 + ($random(seed) & 15));
          d = $random(seed);
          w = 1'(($random(seed) >> 3) & 1);
          pend[p].push_back({w, a, d});
        end
      end
      step_cycle();
    end
  endtask

  initial begin
    int idx;
    int base;
    bit done;
    clk          = 1'b0;
    reset        = 1'b1;
    x_val        = '0;
    x_waddr      = '0;
    x_wdata      = '0;
    x_wen        = '0;
    dbg_raddr    = '0;
    rd_ptr       = '0;
    seed         = 32'h4cc0_9175;
    ptr_m        = 0;
    seq_m        = '0;
    cmp_errors   = 0;
    other_errors = 0;
    for (int i = 0; i < wb_pkg::NUM_REGS; i++) begin
      shadow[i] = '0;
    end
    $readmemh("dv/wb_golden.txt", golden);

    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // Reset state with every register read once
    repeat (wb_pkg::NUM_REGS) step_cycle();

    //----------------------------
    // Stimulus records
    //----------------------------
    idx  = 0;
    done = 1'b0;
    while (!done && idx < max_recs) begin
      base = idx * rec_words;
      case (golden[base])
        32'd1: begin
          for (int p = 0; p < num_pipes; p++) begin
            if (golden[base+1][p]) begin
              pend[p].push_back({golden[base+4+3*p][0], golden[base+2+3*p][4:0],
                                 golden[base+3+3*p]});
            end
          end
          step_cycle();
        end
        32'd2: random_stretch(int'(golden[base+1]));
        32'd3: begin
          for (int i = 0; i < int'(golden[base+2]); i++) begin
            pend[golden[base+1]].push_back({1'b1, golden[base+3][4:0],
                                            golden[base+4] + 32'(i)});
          end
          drain();
        end
        32'd4: begin
          repeat (int'(golden[base+1])) step_cycle();
          drain();
        end
        default: done = 1'b1;
      endcase
      if (!done) begin
        idx++;
      end
    end
    drain();

    // Final register contents from the golden file
    while (idx < max_recs && golden[idx*rec_words] == 32'd5) begin
      base = idx * rec_words;
      @(posedge clk);
      dbg_raddr <= golden[base+1][4:0];
      @(negedge clk);
      compare("dbg_rdata", 64'(dbg_rdata), 64'(golden[base+2]));
      idx++;
    end

    $display("errors: %0d compare, %0d other", cmp_errors, other_errors);
    if (cmp_errors + other_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: dv/wb_golden.txt
// kind a b c d e f g, eight hex words per record
// 1 cycle: a=val mask, then waddr wdata wen for pipe 0 and pipe 1
// 2 random: a=cycles / 3 burst: a=pipe b=count c=waddr d=data base
// 4 idle then drain: a=cycles / 5 expected reg: a=addr b=value / 0 end
3 0 12c 5 1000 0 0 0
3 1 4 6 600 0 0 0
1 3 1 11110000 1 2 22220000 1
1 3 1 11110001 1 2 22220001 1
1 3 1 11110002 1 2 22220002 1
1 3 1 11110003 1 2 22220003 1
1 1 0 deadbeef 1 0 0 0
1 2 0 0 0 3 33 0
4 4 0 0 0 0 0 0
2 28 0 0 0 0 0 0
4 4 0 0 0 0 0 0
1 3 1 a1 1 2 b2 1
1 1 3 c3 1 0 0 0
4 2 0 0 0 0 0 0
5 0 0 0 0 0 0 0
5 1 a1 0 0 0 0 0
5 2 b2 0 0 0 0 0
5 3 c3 0 0 0 0 0
5 5 112b 0 0 0 0 0
5 6 603 0 0 0 0 0
0 0 0 0 0 0 0 0

// File: project.f
hw/wb_pkg.sv
hw/wb_arbiter.sv
hw/wb_commit.sv
hw/wb_regfile.sv
hw/wb_top.sv
dv/wb_checker.sv
dv/wb_tb.sv

// File: run.sh
#!/bin/bash
# Build and run the writeback-commit simulation with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module wb_tb \
  -o wb_sim --Mdir obj_dir || exit 1
out="$(./obj_dir/wb_sim)"
echo "$out"
echo "$out" | grep -qx "TB PASSED" && exit 0 || exit 1
